/* verilog.f */
+incdir+verilog
verilog/uart_pkg.sv
verilog/axil_pkg.sv
verilog/uart_fifo.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_csr.sv
verilog/uart_top.sv
verification/uart_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = uart_tb
RTL_TOP    = uart_top
FILELIST   = verilog.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/uart_tb.sv */
`include "uart_macros.svh"

module uart_tb import axil_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_CYCLES = 64;
	localparam int TABLE_LEN   = 6;
	localparam int OVR_LEN     = 17;
	localparam int FIFO_DEPTH  = 16;

	// STATUS bit weights
	localparam logic [31:0] ST_RX_EMPTY  = 32'h01;
	localparam logic [31:0] ST_RX_FULL   = 32'h02;
	localparam logic [31:0] ST_TX_EMPTY  = 32'h04;
	localparam logic [31:0] ST_FRAME_ERR = 32'h10;
	localparam logic [31:0] ST_OVERRUN   = 32'h20;

	// Byte and the RXDATA word it should read back as
	typedef struct packed {
		logic [7:0]  data;
		logic [31:0] exp_word;
	} table_entry_t;

	table_entry_t stim [TABLE_LEN] = '{
		'{8'h55, 32'h0000_0155},
		'{8'ha3, 32'h0000_01a3},
		'{8'h00, 32'h0000_0100},
		'{8'hff, 32'h0000_01ff},
		'{8'h0f, 32'h0000_010f},
		'{8'h81, 32'h0000_0181}
	};

	logic clk;
	logic reset;
	logic rxd;
	logic txd;
	axil_req_t req;
	axil_rsp_t rsp;
	int errors;
	int bit_cycles;
	logic [31:0] lfsr;
	logic [7:0] ovr [OVR_LEN];

	uart_top u_dut (
		.clk      (clk),
		.reset    (reset),
		.axil_req (req),
		.axil_rsp (rsp),
		.rxd      (rxd),
		.txd      (txd)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////////
	// Helpers

	// Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	// One LFSR step per bit
	task automatic random_byte(output logic [7:0] b);
		int i;
		for (i = 0; i < 8; i++)
		begin
			b[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("Fail %0d ns: %s, got %h, expected %h", $time, what, got, exp);
	endtask

	task automatic timeout_abort(input string what);
		$display("Timeout at %0d ns while waiting for %s", $time, what);
		$display("Errors: %0d", errors + 1);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////////
	// AXI4-Lite master

	task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		@(posedge clk);
		#1;
		req.aw_valid = 1'b1;
		req.aw_addr  = addr;
		req.w_valid  = 1'b1;
		req.w_data   = data;
		req.b_ready  = 1'b1;
		n = 0;
		// Address and data go in the same cycle
		@(negedge clk);
		while (!rsp.aw_ready)
		begin
			n++;
			if (n > WAIT_CYCLES)
				timeout_abort("write handshake");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		req.aw_valid = 1'b0;
		req.w_valid  = 1'b0;
		n = 0;
		@(negedge clk);
		while (!rsp.b_valid)
		begin
			n++;
			if (n > WAIT_CYCLES)
				timeout_abort("write response");
			@(negedge clk);
		end
		resp = rsp.b_resp;
		// b_ready seen high on this edge
		@(posedge clk);
		#1;
		req.b_ready = 1'b0;
	endtask

	task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		@(posedge clk);
		#1;
		req.ar_valid = 1'b1;
		req.ar_addr  = addr;
		req.r_ready  = 1'b1;
		n = 0;
		@(negedge clk);
		while (!rsp.ar_ready)
		begin
			n++;
			if (n > WAIT_CYCLES)
				timeout_abort("read handshake");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		req.ar_valid = 1'b0;
		n = 0;
		@(negedge clk);
		while (!rsp.r_valid)
		begin
			n++;
			if (n > WAIT_CYCLES)
				timeout_abort("read data");
			@(negedge clk);
		end
		data = rsp.r_data;
		resp = rsp.r_resp;
		@(posedge clk);
		#1;
		req.r_ready = 1'b0;
	endtask

	// Repeated STATUS reads until the masked bits match
	task automatic poll_status(input logic [31:0] mask, input logic [31:0] value,
		input string what, output logic [31:0] status);
		logic [1:0] resp;
		int n;
		n = 0;
		axil_read(STATUS, status, resp);
		while ((status & mask) !== value)
		begin
			n++;
			if (n > 4 * bit_cycles)
				timeout_abort(what);
			axil_read(STATUS, status, resp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Serial line model

	// Start bit, 8 data bits LSB first and a stop bit
	task automatic send_frame(input logic [7:0] data, input logic stop);
		logic [9:0] frame;
		int i;
		frame = {stop, data, 1'b0};
		@(posedge clk);
		for (i = 0; i < 10; i++)
		begin
			#1;
			rxd = frame[i];
			repeat (bit_cycles) @(posedge clk);
		end
		#1;
		rxd = 1'b1;
	endtask

	// Samples txd at mid-bit on falling clock edges
	task automatic recv_frame(output logic [7:0] data, output logic stop);
		int n;
		int i;
		n = 0;
		@(negedge clk);
		while (txd)
		begin
			n++;
			if (n > 12 * bit_cycles)
				timeout_abort("start bit on txd");
			@(negedge clk);
		end
		// Centre of start bit
		repeat (bit_cycles / 2) @(negedge clk);
		if (txd !== 1'b0)
			report_mismatch("txd start bit", {31'b0, txd}, 32'h0);
		for (i = 0; i < 8; i++)
		begin
			repeat (bit_cycles) @(negedge clk);
			data[i] = txd;
		end
		repeat (bit_cycles) @(negedge clk);
		stop = txd;
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial
	begin
		logic [31:0] rdata;
		logic [1:0] resp;
		logic [1:0] tx_resp;
		logic [7:0] got;
		logic stop;
		int i;
		int n;

		clk        = 1'b0;
		reset      = 1'b1;
		rxd        = 1'b1;
		req        = '0;
		errors     = 0;
		lfsr       = 32'hd457_c5fb;
		bit_cycles = `UART_OVERSAMPLE * `UART_DIVISOR_RESET;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset values
		axil_read(STATUS, rdata, resp);
		if (rdata !== (ST_RX_EMPTY | ST_TX_EMPTY))
			report_mismatch("STATUS after reset", rdata, ST_RX_EMPTY | ST_TX_EMPTY);
		if (resp !== OKAY)
			report_mismatch("STATUS read response", {30'b0, resp}, 32'h0);
		axil_read(DIVISOR, rdata, resp);
		if (rdata !== 32'd2)
			report_mismatch("DIVISOR after reset", rdata, 32'd2);
		if (txd !== 1'b1)
			report_mismatch("txd after reset", {31'b0, txd}, 32'h1);

		// Transmit table bytes while the line model listens
		fork
			begin
				for (i = 0; i < TABLE_LEN; i++)
				begin
					axil_write(TXDATA, {24'h0, stim[i].data}, tx_resp);
					if (tx_resp !== OKAY)
						report_mismatch("TXDATA write response", {30'b0, tx_resp}, 32'h0);
				end
			end
			begin
				for (n = 0; n < TABLE_LEN; n++)
				begin
					recv_frame(got, stop);
					if (got !== stim[n].data)
						report_mismatch("byte on txd", {24'h0, got}, {24'h0, stim[n].data});
					if (stop !== 1'b1)
						report_mismatch("stop bit on txd", {31'b0, stop}, 32'h1);
				end
			end
		join
		poll_status(ST_TX_EMPTY, ST_TX_EMPTY, "transmit FIFO to drain", rdata);

		// Receive the same table on rxd
		for (i = 0; i < TABLE_LEN; i++)
			send_frame(stim[i].data, 1'b1);
		poll_status(ST_RX_EMPTY, 32'h0, "received bytes", rdata);
		for (i = 0; i < TABLE_LEN; i++)
		begin
			axil_read(RXDATA, rdata, resp);
			if (rdata !== stim[i].exp_word)
				report_mismatch("RXDATA word", rdata, stim[i].exp_word);
		end
		axil_read(RXDATA, rdata, resp);
		if (rdata !== 32'h0)
			report_mismatch("RXDATA when empty", rdata, 32'h0);

		// Low stop bit
		send_frame(8'hc3, 1'b0);
		poll_status(ST_FRAME_ERR, ST_FRAME_ERR, "frame error flag", rdata);
		if (rdata !== (ST_RX_EMPTY | ST_TX_EMPTY | ST_FRAME_ERR))
			report_mismatch("STATUS after frame error", rdata,
				ST_RX_EMPTY | ST_TX_EMPTY | ST_FRAME_ERR);
		axil_write(STATUS, ST_FRAME_ERR, resp);
		axil_read(STATUS, rdata, resp);
		if (rdata !== (ST_RX_EMPTY | ST_TX_EMPTY))
			report_mismatch("STATUS after frame error clear", rdata,
				ST_RX_EMPTY | ST_TX_EMPTY);

		// One byte more than the receive FIFO holds
		for (i = 0; i < OVR_LEN; i++)
			random_byte(ovr[i]);
		for (i = 0; i < OVR_LEN; i++)
			send_frame(ovr[i], 1'b1);
		poll_status(ST_OVERRUN, ST_OVERRUN, "overrun flag", rdata);
		if (rdata !== (ST_RX_FULL | ST_TX_EMPTY | ST_OVERRUN))
			report_mismatch("STATUS after overrun", rdata,
				ST_RX_FULL | ST_TX_EMPTY | ST_OVERRUN);
		for (i = 0; i < FIFO_DEPTH; i++)
		begin
			axil_read(RXDATA, rdata, resp);
			if (rdata !== {23'h0, 1'b1, ovr[i]})
				report_mismatch("RXDATA after overrun", rdata, {23'h0, 1'b1, ovr[i]});
		end
		axil_write(STATUS, ST_OVERRUN, resp);
		axil_read(STATUS, rdata, resp);
		if (rdata !== (ST_RX_EMPTY | ST_TX_EMPTY))
			report_mismatch("STATUS after overrun clear", rdata, ST_RX_EMPTY | ST_TX_EMPTY);

		// Slower baud of 64 clocks per bit
		axil_write(DIVISOR, 32'd4, resp);
		axil_read(DIVISOR, rdata, resp);
		if (rdata !== 32'd4)
			report_mismatch("DIVISOR readback", rdata, 32'd4);
		bit_cycles = `UART_OVERSAMPLE * 4;
		fork
			axil_write(TXDATA, 32'h0000_0096, tx_resp);
			recv_frame(got, stop);
		join
		if (got !== 8'h96)
			report_mismatch("byte on txd at divisor 4", {24'h0, got}, 32'h96);
		if (stop !== 1'b1)
			report_mismatch("stop bit at divisor 4", {31'b0, stop}, 32'h1);

		// Unmapped addresses
		axil_write(4'h2, 32'h0000_00aa, resp);
		if (resp !== SLVERR)
			report_mismatch("write response at 0x2", {30'b0, resp}, 32'h2);
		axil_read(4'he, rdata, resp);
		if (resp !== SLVERR)
			report_mismatch("read response at 0xE", {30'b0, resp}, 32'h2);
		if (rdata !== 32'h0)
			report_mismatch("read data at 0xE", rdata, 32'h0);

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* verilog/uart_top.sv */
`include "uart_macros.svh"

module uart_top import uart_pkg::*, axil_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input  logic      rxd,
	output logic      txd
);

	logic tick;
	// Transmit path
	logic tx_wr, tx_rd, tx_empty, tx_full;
	logic [`UART_DATA_BITS-1:0] tx_wdata, tx_rdata;
	// Receive path
	rx_byte_t rx_byte;
	logic rx_valid, rx_rd, rx_empty, rx_full;
	logic [`UART_DATA_BITS-1:0] rx_rdata;

	//////////////////////////////////////////////////////////////////////////
	// Bus side

	uart_csr u_csr (
		.clk         (clk),
		.reset       (reset),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.tick        (tick),
		.tx_wr       (tx_wr),
		.tx_wdata    (tx_wdata),
		.tx_empty    (tx_empty),
		.tx_full     (tx_full),
		.rx_in       (rx_byte),
		.rx_in_valid (rx_valid),
		.rx_rd       (rx_rd),
		.rx_rdata    (rx_rdata),
		.rx_empty    (rx_empty),
		.rx_full     (rx_full)
	);

	//////////////////////////////////////////////////////////////////////////
	// Transmit FIFO and shifter

	uart_fifo #(
		.DATA_W (`UART_DATA_BITS),
		.ADDR_W (`UART_FIFO_ADDR_BITS)
	) u_tx_fifo (
		.clk    (clk),
		.reset  (reset),
		.rd     (tx_rd),
		.wr     (tx_wr),
		.w_data (tx_wdata),
		.empty  (tx_empty),
		.full   (tx_full),
		.r_data (tx_rdata)
	);

	uart_tx u_tx (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.fifo_empty (tx_empty),
		.fifo_data  (tx_rdata),
		.fifo_rd    (tx_rd),
		.txd        (txd)
	);

	//////////////////////////////////////////////////////////////////////////
	// Receiver and receive FIFO

	uart_rx u_rx (
		.clk          (clk),
		.reset        (reset),
		.tick         (tick),
		.rxd          (rxd),
		.rx_out       (rx_byte),
		.rx_out_valid (rx_valid)
	);

	// Only good frames are stored
	uart_fifo #(
		.DATA_W (`UART_DATA_BITS),
		.ADDR_W (`UART_FIFO_ADDR_BITS)
	) u_rx_fifo (
		.clk    (clk),
		.reset  (reset),
		.rd     (rx_rd),
		.wr     (rx_valid && !rx_byte.frame_err),
		.w_data (rx_byte.data),
		.empty  (rx_empty),
		.full   (rx_full),
		.r_data (rx_rdata)
	);

endmodule

/* verilog/uart_csr.sv */
`include "uart_macros.svh"

module uart_csr import uart_pkg::*, axil_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  axil_req_t                  axil_req,
	output axil_rsp_t                  axil_rsp,
	output logic                       tick,
	output logic                       tx_wr,
	output logic [`UART_DATA_BITS-1:0] tx_wdata,
	input  logic                       tx_empty,
	input  logic                       tx_full,
	input  rx_byte_t                   rx_in,
	input  logic                       rx_in_valid,
	output logic                       rx_rd,
	input  logic [`UART_DATA_BITS-1:0] rx_rdata,
	input  logic                       rx_empty,
	input  logic                       rx_full
);

	localparam int DIV_W = 16;
	localparam int STATUS_W = $bits(uart_status_t);

	logic [DIV_W-1:0] divisor, baud_cnt;
	logic wr_hs, rd_hs;
	csr_addr_e wr_addr, rd_addr;
	axil_resp_e wr_resp, rd_resp, b_resp, r_resp;
	logic b_valid, r_valid;
	logic [`AXIL_DATA_W-1:0] rd_word, r_data;
	logic frame_err, overrun;
	logic frame_err_clr, overrun_clr, div_wr;
	uart_status_t status, clr_mask;

	//////////////////////////////////////////////////////////////////////////
	// Baud tick, one pulse every divisor clocks

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			baud_cnt <= '0;
			tick     <= 1'b0;
		end
		// Compare with >= so a smaller new divisor wraps at once
		else if (baud_cnt >= divisor - 1'b1)
		begin
			baud_cnt <= '0;
			tick     <= 1'b1;
		end
		else
		begin
			baud_cnt <= baud_cnt + 1'b1;
			tick     <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Address decode

	// Handshakes blocked only by a pending response on the same channel
	assign wr_hs = axil_req.aw_valid && axil_req.w_valid && !b_valid;
	assign rd_hs = axil_req.ar_valid && !r_valid;

	assign wr_addr  = csr_addr_e'(axil_req.aw_addr);
	assign rd_addr  = csr_addr_e'(axil_req.ar_addr);
	assign clr_mask = uart_status_t'(axil_req.w_data[STATUS_W-1:0]);
	assign tx_wdata = axil_req.w_data[`UART_DATA_BITS-1:0];

	// Write side effects
	always_comb
	begin
		tx_wr         = 1'b0;
		div_wr        = 1'b0;
		frame_err_clr = 1'b0;
		overrun_clr   = 1'b0;
		wr_resp       = OKAY;
		case (wr_addr)
			TXDATA:  tx_wr = wr_hs && !tx_full;
			RXDATA:  tx_wr = 1'b0;
			STATUS:
			begin
				// Write 1 to clear
				frame_err_clr = wr_hs && clr_mask.frame_err;
				overrun_clr   = wr_hs && clr_mask.overrun;
			end
			// Zero divisor would stall the tick
			DIVISOR: div_wr = wr_hs && (axil_req.w_data[DIV_W-1:0] != '0);
			default: wr_resp = SLVERR;
		endcase
	end

	assign status = '{
		overrun:   overrun,
		frame_err: frame_err,
		tx_full:   tx_full,
		tx_empty:  tx_empty,
		rx_full:   rx_full,
		rx_empty:  rx_empty
	};

	// Read mux, RXDATA pops at the ar handshake
	always_comb
	begin
		rx_rd   = 1'b0;
		rd_word = '0;
		rd_resp = OKAY;
		case (rd_addr)
			TXDATA:  rd_word = '0;
			RXDATA:
			begin
				rx_rd = rd_hs && !rx_empty;
				// Valid flag just above the byte
				if (!rx_empty)
					rd_word[`UART_DATA_BITS:0] = {1'b1, rx_rdata};
			end
			STATUS:  rd_word[STATUS_W-1:0] = status;
			DIVISOR: rd_word[DIV_W-1:0] = divisor;
			default: rd_resp = SLVERR;
		endcase
	end

	//////////////////////////////////////////////////////////////////////////
	// Registers

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			divisor   <= DIV_W'(`UART_DIVISOR_RESET);
			frame_err <= 1'b0;
			overrun   <= 1'b0;
		end
		else
		begin
			if (div_wr)
				divisor <= axil_req.w_data[DIV_W-1:0];
			// New event wins over a clear in the same cycle
			frame_err <= (frame_err && !frame_err_clr) || (rx_in_valid && rx_in.frame_err);
			overrun   <= (overrun && !overrun_clr)
				|| (rx_in_valid && !rx_in.frame_err && rx_full);
		end
	end

	// Response channels
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			b_valid <= 1'b0;
			b_resp  <= OKAY;
			r_valid <= 1'b0;
			r_resp  <= OKAY;
		end
		else
		begin
			if (wr_hs)
			begin
				b_valid <= 1'b1;
				b_resp  <= wr_resp;
			end
			else if (axil_req.b_ready)
				b_valid <= 1'b0;
			if (rd_hs)
			begin
				r_valid <= 1'b1;
				r_resp  <= rd_resp;
			end
			else if (axil_req.r_ready)
				r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_hs)
			r_data <= rd_word;
	end

	always_comb
	begin
		axil_rsp.aw_ready = wr_hs;
		axil_rsp.w_ready  = wr_hs;
		axil_rsp.b_valid  = b_valid;
		axil_rsp.b_resp   = b_resp;
		axil_rsp.ar_ready = rd_hs;
		axil_rsp.r_valid  = r_valid;
		axil_rsp.r_data   = r_data;
		axil_rsp.r_resp   = r_resp;
	end

endmodule

/* verilog/uart_tx.sv */
`include "uart_macros.svh"

module uart_tx import uart_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       tick,
	input  logic                       fifo_empty,
	input  logic [`UART_DATA_BITS-1:0] fifo_data,
	output logic                       fifo_rd,
	output logic                       txd
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

	tx_state_e state;
	logic bit_end;
	logic [TICK_W-1:0] tick_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [`UART_DATA_BITS-1:0] shift_reg;

	// Frame starts on a tick, popping the head byte at once
	assign fifo_rd = (state == TX_IDLE) && tick && !fifo_empty;

	assign bit_end = tick && (tick_cnt == TICK_LAST);

	// Outgoing byte, shifted right after each data bit
	always_ff @(posedge clk)
	begin
		if (fifo_rd)
			shift_reg <= fifo_data;
		else if (state == TX_DATA && bit_end)
			shift_reg <= shift_reg >> 1;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			txd      <= 1'b1;
		end
		else
		begin
			if (state != TX_IDLE && tick)
				tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
			case (state)
				TX_IDLE:
				begin
					if (fifo_rd)
					begin
						// Start bit
						txd      <= 1'b0;
						tick_cnt <= '0;
						state    <= TX_START;
					end
				end
				TX_START:
				begin
					if (bit_end)
					begin
						txd     <= shift_reg[0];
						bit_cnt <= '0;
						state   <= TX_DATA;
					end
				end
				TX_DATA:
				begin
					if (bit_end && bit_cnt == BIT_LAST)
					begin
						// Stop bit
						txd   <= 1'b1;
						state <= TX_STOP;
					end
					else if (bit_end)
					begin
						// Next bit is bit 1 of the unshifted byte
						txd     <= shift_reg[1];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				TX_STOP:
				begin
					if (bit_end)
						state <= TX_IDLE;
				end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

endmodule

/* verilog/uart_rx.sv */
`include "uart_macros.svh"

module uart_rx import uart_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     tick,
	input  logic     rxd,
	output rx_byte_t rx_out,
	output logic     rx_out_valid
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

	rx_state_e state;
	logic rxd_meta, rxd_sync, rxd_prev;
	logic rxd_fall;
	logic bit_end;
	logic [TICK_W-1:0] tick_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [`UART_DATA_BITS-1:0] shift_reg;
	logic frame_err;

	// Two-flop synchronizer plus one stage for edge detect
	// Line idles high
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign rxd_fall = rxd_prev && !rxd_sync;

	// Last tick of a full bit period
	assign bit_end = tick && (tick_cnt == TICK_LAST);

	// Data bits, LSB first, enter from the top
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && bit_end)
			shift_reg <= {rxd_sync, shift_reg[`UART_DATA_BITS-1:1]};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state        <= RX_IDLE;
			tick_cnt     <= '0;
			bit_cnt      <= '0;
			frame_err    <= 1'b0;
			rx_out_valid <= 1'b0;
		end
		else
		begin
			rx_out_valid <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					// Tick count restarts at the falling edge
					if (rxd_fall)
					begin
						tick_cnt <= '0;
						state    <= RX_START;
					end
				end
				RX_START:
				begin
					if (tick && tick_cnt == TICK_MID)
					begin
						// Mid start bit, high line means a glitch
						tick_cnt <= '0;
						bit_cnt  <= '0;
						state    <= rxd_sync ? RX_IDLE : RX_DATA;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (bit_end)
					begin
						tick_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_LAST)
							state <= RX_STOP;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				RX_STOP:
				begin
					if (bit_end)
					begin
						// Low stop bit is a frame error
						frame_err    <= !rxd_sync;
						rx_out_valid <= 1'b1;
						state        <= RX_IDLE;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// Byte stays stable until the next frame's data phase
	assign rx_out = '{frame_err: frame_err, data: shift_reg};

endmodule

/* verilog/uart_fifo.sv */
module uart_fifo #(
	parameter int DATA_W = 8,
	parameter int ADDR_W = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              rd,
	input  logic              wr,
	input  logic [DATA_W-1:0] w_data,
	output logic              empty,
	output logic              full,
	output logic [DATA_W-1:0] r_data
);

	logic [DATA_W-1:0] mem [0:2**ADDR_W-1];
	logic [ADDR_W-1:0] w_ptr, w_ptr_next, w_ptr_succ;
	logic [ADDR_W-1:0] r_ptr, r_ptr_next, r_ptr_succ;
	logic full_reg, full_next;
	logic empty_reg, empty_next;
	logic do_wr, do_rd;

	// Requests that can actually be served
	// Read on empty drops out, so read plus write on empty is a plain write
	assign do_wr = wr && !full_reg;
	assign do_rd = rd && !empty_reg;

	// Storage, written at the tail
	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[w_ptr] <= w_data;
	end

	// Head entry always visible
	assign r_data = mem[r_ptr];

	//////////////////////////////////////////////////////////////////////////
	// Pointers and flags

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			w_ptr     <= '0;
			r_ptr     <= '0;
			full_reg  <= 1'b0;
			empty_reg <= 1'b1;
		end
		else
		begin
			w_ptr     <= w_ptr_next;
			r_ptr     <= r_ptr_next;
			full_reg  <= full_next;
			empty_reg <= empty_next;
		end
	end

	always_comb
	begin
		w_ptr_succ = w_ptr + 1'b1;
		r_ptr_succ = r_ptr + 1'b1;
		w_ptr_next = w_ptr;
		r_ptr_next = r_ptr;
		full_next  = full_reg;
		empty_next = empty_reg;
		case ({do_wr, do_rd})
			// Pop only
			2'b01:
			begin
				r_ptr_next = r_ptr_succ;
				full_next  = 1'b0;
				if (r_ptr_succ == w_ptr)
					empty_next = 1'b1;
			end
			// Push only
			2'b10:
			begin
				w_ptr_next = w_ptr_succ;
				empty_next = 1'b0;
				if (w_ptr_succ == r_ptr)
					full_next = 1'b1;
			end
			// Pass through, occupancy unchanged
			2'b11:
			begin
				w_ptr_next = w_ptr_succ;
				r_ptr_next = r_ptr_succ;
			end
			default:
			begin
			end
		endcase
	end

	assign full  = full_reg;
	assign empty = empty_reg;

endmodule

/* verilog/axil_pkg.sv */
`include "uart_macros.svh"

package axil_pkg;

	// Response codes
	typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} axil_resp_e;

	// Register map
	typedef enum logic [`AXIL_ADDR_W-1:0] {
		TXDATA  = 'h0,
		RXDATA  = 'h4,
		STATUS  = 'h8,
		DIVISOR = 'hC
	} csr_addr_e;

	// Master to slave
	typedef struct packed {
		logic                   aw_valid;
		logic [`AXIL_ADDR_W-1:0] aw_addr;
		logic                   w_valid;
		logic [`AXIL_DATA_W-1:0] w_data;
		logic                   b_ready;
		logic                   ar_valid;
		logic [`AXIL_ADDR_W-1:0] ar_addr;
		logic                   r_ready;
	} axil_req_t;

	// Slave to master
	typedef struct packed {
		logic                   aw_ready;
		logic                   w_ready;
		logic                   b_valid;
		axil_resp_e             b_resp;
		logic                   ar_ready;
		logic                   r_valid;
		logic [`AXIL_DATA_W-1:0] r_data;
		axil_resp_e             r_resp;
	} axil_rsp_t;

endpackage

/* verilog/uart_pkg.sv */
`include "uart_macros.svh"

package uart_pkg;

	// Receiver FSM
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	// Transmitter FSM
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

	// Byte out of the receiver
	typedef struct packed {
		logic                       frame_err;
		logic [`UART_DATA_BITS-1:0] data;
	} rx_byte_t;

	// STATUS register, rx_empty at bit 0
	typedef struct packed {
		logic overrun;
		logic frame_err;
		logic tx_full;
		logic tx_empty;
		logic rx_full;
		logic rx_empty;
	} uart_status_t;

endpackage

/* verilog/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Character format, 8N1
`define UART_DATA_BITS 8

// FIFO depth is 2**UART_FIFO_ADDR_BITS
`define UART_FIFO_ADDR_BITS 4

// Ticks per serial bit
`define UART_OVERSAMPLE 16

// Clocks per tick after reset
`define UART_DIVISOR_RESET 2

// AXI4-Lite bus widths
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32

`endif
